// ==== include/video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

//////////////////////////////
// raster geometry
//////////////////////////////
`define H_ACTIVE          8                        // visible pixels per line
`define V_ACTIVE          4                        // visible lines
`define H_TOTAL           12                       // clocks per line, blanking included
`define V_TOTAL           6                        // lines per frame
`define HS_START          9                        // first column with hs high
`define HS_WIDTH          2                        // hs pulse length in clocks
`define VS_LINE           5                        // only line with vs high

//////////////////////////////
// frame store
//////////////////////////////
`define FRAME_WORDS       (`H_ACTIVE * `V_ACTIVE)  // one full frame of pixels
`define ADDR_W            5                        // log2 of FRAME_WORDS

//////////////////////////////
// timers
//////////////////////////////
`define STARTUP_CYCLES    20                       // reset release to ready
`define HEARTBEAT_CYCLES  50                       // led half period

`endif

// ==== src/video_pkg.sv ====
`include "video_defs.svh"

package video_pkg;

    typedef logic [7:0]          cam_byte_t;   // one byte off the camera bus
    typedef logic [15:0]         rgb565_t;     // r[15:11] g[10:5] b[4:0]
    typedef logic [7:0]          chan8_t;      // one output colour channel
    typedef logic [3:0]          hcount_t;     // column, 0..H_TOTAL-1
    typedef logic [2:0]          vcount_t;     // line, 0..V_TOTAL-1
    typedef logic [`ADDR_W-1:0]  addr_t;       // frame store address

    // display sync group, all three move together
    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } sync_t;

    // packed camera pixel with its frame marker
    typedef struct packed {
        logic    vsync;                        // delayed camera vsync
        logic    valid;                        // one cycle per pixel
        rgb565_t pixel;                        // already red/blue swapped
    } cam_pix_t;

    typedef struct packed {
        logic  en;                             // read strobe
        addr_t addr;
    } rd_req_t;

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    // capture/display sequencing
    typedef enum logic [1:0] {
        S_STARTUP = 2'd0,                      // waiting for ready
        S_SEEK    = 2'd1,                      // waiting for a frame start
        S_CAPTURE = 2'd2,                      // writing the first frame
        S_SHOW    = 2'd3                       // frame complete, raster running
    } frame_state_t;

    // write side control for the frame store
    typedef struct packed {
        logic restart;                         // pointer back to zero
        logic enable;                          // accept camera pixels
    } wr_ctl_t;

    typedef logic [7:0] timer_cnt_t;           // startup and heartbeat counts

endpackage

// ==== src/startup_timer.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module startup_timer (
    input  logic core_clk,
    input  logic rst_i,
    output logic ready_o,                      // high for good after startup
    output logic heartbeat_o                   // led toggle
);

    ctrl_pkg::timer_cnt_t start_cnt;           // counts up to release, then holds
    ctrl_pkg::timer_cnt_t beat_cnt;            // heartbeat divider
    logic                 ready;
    logic                 beat_wrap;

    assign ready     = (start_cnt == ctrl_pkg::timer_cnt_t'(`STARTUP_CYCLES));
    assign beat_wrap = (beat_cnt == ctrl_pkg::timer_cnt_t'(`HEARTBEAT_CYCLES - 1));
    assign ready_o   = ready;

    //////////////////////////////
    // release delay
    //////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i)
            start_cnt <= '0;
        else if (!ready)
            start_cnt <= start_cnt + 1'b1;     // saturates at STARTUP_CYCLES
    end

    //////////////////////////////
    // heartbeat
    //////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i || !ready)
            beat_cnt <= '0;                    // idle until ready
        else if (beat_wrap)
            beat_cnt <= '0;
        else
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
            heartbeat_o <= 1'b1;               // led on out of reset
        else if (ready && beat_wrap)
            heartbeat_o <= ~heartbeat_o;
    end

endmodule

// ==== src/frame_ctrl.sv ====
`timescale 1ns/1ns

module frame_ctrl (
    input  logic              core_clk,
    input  logic              rst_i,
    input  logic              ready_i,         // from startup timer
    input  logic              cam_vsync_i,     // delayed camera vsync
    output ctrl_pkg::wr_ctl_t wr_ctl_o,
    output logic              show_en_o        // lets the raster run
);

    ctrl_pkg::frame_state_t state;
    ctrl_pkg::frame_state_t state_nxt;
    logic                   vsync_prev;
    logic                   vsync_rise;

    assign vsync_rise = cam_vsync_i & ~vsync_prev;  // frame start marker

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
            vsync_prev <= 1'b0;
        else
            vsync_prev <= cam_vsync_i;
    end

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_comb
    begin
        state_nxt = state;
        unique case (state)
            ctrl_pkg::S_STARTUP:
                if (ready_i)
                    state_nxt = ctrl_pkg::S_SEEK;
            ctrl_pkg::S_SEEK:
                if (vsync_rise)
                    state_nxt = ctrl_pkg::S_CAPTURE;  // first frame boundary
            ctrl_pkg::S_CAPTURE:
                if (vsync_rise)
                    state_nxt = ctrl_pkg::S_SHOW;     // whole frame is in
            ctrl_pkg::S_SHOW:
                state_nxt = ctrl_pkg::S_SHOW;         // stays, store keeps refreshing
            default:
                state_nxt = ctrl_pkg::S_STARTUP;
        endcase
    end

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
            state <= ctrl_pkg::S_STARTUP;
        else
            state <= state_nxt;
    end

    // restart on every frame start once out of startup
    assign wr_ctl_o.restart = vsync_rise && (state != ctrl_pkg::S_STARTUP);
    assign wr_ctl_o.enable  = (state == ctrl_pkg::S_CAPTURE) || (state == ctrl_pkg::S_SHOW);
    assign show_en_o        = (state == ctrl_pkg::S_SHOW);

endmodule

// ==== src/cam_pixel_pack.sv ====
`timescale 1ns/1ns

module cam_pixel_pack (
    input  logic                 core_clk,
    input  logic                 rst_i,
    input  video_pkg::cam_byte_t cam_data_i,
    input  logic                 cam_href_i,   // bytes valid while high
    input  logic                 cam_vsync_i,
    output video_pkg::cam_pix_t  cam_pix_o
);

    video_pkg::cam_byte_t data_q;              // input stage
    logic                 href_q;
    logic                 vsync_q;
    logic                 vsync_qq;            // matches pixel delay
    logic                 odd_byte;            // next byte completes a word
    video_pkg::cam_byte_t hi_byte;             // first byte of the pair
    logic [15:0]          cam_word;
    video_pkg::rgb565_t   pix_q;
    logic                 valid_q;

    always_ff @(posedge core_clk)
    begin
        data_q <= cam_data_i;                  // payload, no reset
        if (rst_i)
        begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end
        else
        begin
            href_q  <= cam_href_i;
            vsync_q <= cam_vsync_i;
        end
    end

    assign cam_word = {hi_byte, data_q};       // high byte arrives first

    //////////////////////////////
    // byte pairing
    //////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i || !href_q)
            odd_byte <= 1'b0;                  // dangling odd byte is dropped here
        else
            odd_byte <= ~odd_byte;
    end

    always_ff @(posedge core_clk)
    begin
        if (href_q && !odd_byte)
            hi_byte <= data_q;
        if (href_q && odd_byte)
            pix_q <= {cam_word[4:0], cam_word[10:5], cam_word[15:11]};  // red/blue swap
    end

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            valid_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end
        else
        begin
            valid_q  <= href_q && odd_byte;    // one pulse per pair
            vsync_qq <= vsync_q;
        end
    end

    assign cam_pix_o = '{vsync: vsync_qq, valid: valid_q, pixel: pix_q};

endmodule

// ==== src/frame_store.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module frame_store (
    input  logic                core_clk,
    input  logic                rst_i,
    input  video_pkg::cam_pix_t cam_pix_i,
    input  ctrl_pkg::wr_ctl_t   wr_ctl_i,
    input  video_pkg::rd_req_t  rd_req_i,
    output video_pkg::rgb565_t  rd_data_o      // one cycle after the request
);

    video_pkg::rgb565_t mem [0:`FRAME_WORDS-1];
    video_pkg::addr_t   wr_ptr;
    logic               full;                  // pointer has reached FRAME_WORDS
    logic               wr_go;

    assign wr_go = cam_pix_i.valid && wr_ctl_i.enable && !full;

    //////////////////////////////
    // write pointer
    //////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i || wr_ctl_i.restart)
        begin
            wr_ptr <= '0;                      // new frame from the top
            full   <= 1'b0;
        end
        else if (wr_go)
        begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr == video_pkg::addr_t'(`FRAME_WORDS - 1))
                full <= 1'b1;                  // extra pixels are ignored
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (wr_go && !wr_ctl_i.restart)
            mem[wr_ptr] <= cam_pix_i.pixel;
        if (rd_req_i.en)
            rd_data_o <= mem[rd_req_i.addr];   // registered read port
    end

endmodule

// ==== src/video_timing.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module video_timing (
    input  logic               core_clk,
    input  logic               rst_i,
    input  logic               show_en_i,      // counters parked at zero when low
    output video_pkg::sync_t   sync_o,
    output video_pkg::rd_req_t rd_req_o
);

    video_pkg::hcount_t hcnt;
    video_pkg::vcount_t vcnt;
    logic               line_end;
    logic               frame_end;
    logic               active;

    assign line_end  = (hcnt == video_pkg::hcount_t'(`H_TOTAL - 1));
    assign frame_end = (vcnt == video_pkg::vcount_t'(`V_TOTAL - 1));

    //////////////////////////////
    // raster counters
    //////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i || !show_en_i)
        begin
            hcnt <= '0;
            vcnt <= '0;
        end
        else if (line_end)
        begin
            hcnt <= '0;
            vcnt <= frame_end ? '0 : vcnt + 1'b1;
        end
        else
        begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // visible area, only while displaying
    assign active = show_en_i
                 && (hcnt < video_pkg::hcount_t'(`H_ACTIVE))
                 && (vcnt < video_pkg::vcount_t'(`V_ACTIVE));

    //////////////////////////////
    // sync and read request
    //////////////////////////////
    assign sync_o.de = active;
    assign sync_o.hs = show_en_i
                    && (hcnt >= video_pkg::hcount_t'(`HS_START))
                    && (hcnt < video_pkg::hcount_t'(`HS_START + `HS_WIDTH));
    assign sync_o.vs = show_en_i && (vcnt == video_pkg::vcount_t'(`VS_LINE));

    assign rd_req_o.en   = active;             // read only visible pixels
    assign rd_req_o.addr = video_pkg::addr_t'(vcnt) * video_pkg::addr_t'(`H_ACTIVE)
                         + video_pkg::addr_t'(hcnt);  // line * width + column

endmodule

// ==== src/video_out.sv ====
`timescale 1ns/1ns

module video_out (
    input  logic                core_clk,
    input  logic                rst_i,
    input  video_pkg::sync_t    sync_i,        // same cycle as the read request
    input  video_pkg::rgb565_t  pix_i,         // store read data, one cycle later
    output logic                vs_o,
    output logic                hs_o,
    output logic                de_o,
    output video_pkg::chan8_t   r_o,
    output video_pkg::chan8_t   g_o,
    output video_pkg::chan8_t   b_o
);

    video_pkg::sync_t sync_d1;                 // lines up with pix_i

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            sync_d1 <= '0;
            vs_o    <= 1'b0;
            hs_o    <= 1'b0;
            de_o    <= 1'b0;
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
        end
        else
        begin
            sync_d1 <= sync_i;
            vs_o    <= sync_d1.vs;
            hs_o    <= sync_d1.hs;
            de_o    <= sync_d1.de;
            r_o     <= sync_d1.de ? {pix_i[15:11], 3'b000} : '0;  // 5 -> 8 bits
            g_o     <= sync_d1.de ? {pix_i[10:5], 2'b00} : '0;    // 6 -> 8 bits
            b_o     <= sync_d1.de ? {pix_i[4:0], 3'b000} : '0;    // blank outside de
        end
    end

endmodule

// ==== src/cam_display_top.sv ====
`timescale 1ns/1ns

module cam_display_top (
    input  logic                 core_clk,
    input  logic                 rst_i,
    input  video_pkg::cam_byte_t cam_data_i,
    input  logic                 cam_href_i,
    input  logic                 cam_vsync_i,
    output logic                 ready_o,
    output logic                 heartbeat_o,
    output logic                 vs_o,
    output logic                 hs_o,
    output logic                 de_o,
    output video_pkg::chan8_t    r_o,
    output video_pkg::chan8_t    g_o,
    output video_pkg::chan8_t    b_o
);

    logic                ready;
    video_pkg::cam_pix_t cam_pix;              // packed camera pixels
    ctrl_pkg::wr_ctl_t   wr_ctl;
    logic                show_en;
    video_pkg::rd_req_t  rd_req;
    video_pkg::sync_t    sync;                 // raster sync, before alignment
    video_pkg::rgb565_t  rd_data;

    assign ready_o = ready;

    //////////////////////////////
    // control
    //////////////////////////////
    startup_timer u_startup_timer (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .ready_o     (ready),
        .heartbeat_o (heartbeat_o)
    );

    frame_ctrl u_frame_ctrl (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .ready_i     (ready),
        .cam_vsync_i (cam_pix.vsync),          // delayed with the pixels
        .wr_ctl_o    (wr_ctl),
        .show_en_o   (show_en)
    );

    //////////////////////////////
    // video path
    //////////////////////////////
    cam_pixel_pack u_cam_pixel_pack (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .cam_pix_o   (cam_pix)
    );

    frame_store u_frame_store (
        .core_clk  (core_clk),
        .rst_i     (rst_i),
        .cam_pix_i (cam_pix),
        .wr_ctl_i  (wr_ctl),
        .rd_req_i  (rd_req),
        .rd_data_o (rd_data)
    );

    video_timing u_video_timing (
        .core_clk  (core_clk),
        .rst_i     (rst_i),
        .show_en_i (show_en),
        .sync_o    (sync),
        .rd_req_o  (rd_req)
    );

    video_out u_video_out (
        .core_clk (core_clk),
        .rst_i    (rst_i),
        .sync_i   (sync),
        .pix_i    (rd_data),
        .vs_o     (vs_o),
        .hs_o     (hs_o),
        .de_o     (de_o),
        .r_o      (r_o),
        .g_o      (g_o),
        .b_o      (b_o)
    );

endmodule

// ==== test/tb_cam_display.sv ====
`timescale 1ns/1ns
`include "video_defs.svh"

module tb_cam_display;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 8;
    localparam int SETTLE_CYCLES = 4;                  // idle after ready
    localparam int VS_HIGH       = 3;                  // camera vsync pulse
    localparam int VS_LOW        = 6;                  // quiet time after it
    localparam int LINE_GAP      = 4;                  // href low between lines
    localparam int STRAY_CYCLES  = 5;                  // gap, odd byte, gap
    localparam int STRAY_LINE    = 1;
    localparam int FRAME_CYCLES  = `H_TOTAL * `V_TOTAL;
    localparam int STIM_CYCLES   = SETTLE_CYCLES + 2 * (VS_HIGH + VS_LOW)
                                 + `V_ACTIVE * (2 * `H_ACTIVE + LINE_GAP) + STRAY_CYCLES;
    localparam int WATCHDOG_NS   = 4 * (`STARTUP_CYCLES + STIM_CYCLES + 3 * FRAME_CYCLES
                                 + 3 * `HEARTBEAT_CYCLES) * CLK_PERIOD;

    // one camera word and the rgb888 it must come back as
    typedef struct packed {
        logic [15:0] word;
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
    } pix_entry_t;

    logic                 core_clk;
    logic                 rst_i;
    video_pkg::cam_byte_t cam_data_i;
    logic                 cam_href_i;
    logic                 cam_vsync_i;
    logic                 ready_o;
    logic                 heartbeat_o;
    logic                 vs_o;
    logic                 hs_o;
    logic                 de_o;
    video_pkg::chan8_t    r_o;
    video_pkg::chan8_t    g_o;
    video_pkg::chan8_t    b_o;

    pix_entry_t  stim_tab [`FRAME_WORDS];              // raster order
    logic [31:0] lfsr_state = 32'hb7305af6;
    logic [7:0]  stray_byte;
    logic        vsync2_sent;

    cam_display_top dut (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .ready_o     (ready_o),
        .heartbeat_o (heartbeat_o),
        .vs_o        (vs_o),
        .hs_o        (hs_o),
        .de_o        (de_o),
        .r_o         (r_o),
        .g_o         (g_o),
        .b_o         (b_o)
    );

    initial
    begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_val(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        assert (got === exp)
        else abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] draw_bits(input int n);
        logic [15:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);        // one step per bit
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic void build_table();
        logic [15:0] w;
        int          i;
        for (i = 0; i < `FRAME_WORDS; i++)
        begin
            w = draw_bits(16);
            stim_tab[i].word = w;
            stim_tab[i].r    = {w[4:0], 3'b000};       // red from camera low bits
            stim_tab[i].g    = {w[10:5], 2'b00};
            stim_tab[i].b    = {w[15:11], 3'b000};     // blue from camera high bits
        end
        stray_byte = 8'(draw_bits(8));
    endfunction

    //////////////////////////////
    // camera driver
    //////////////////////////////
    task automatic put_byte(input logic [7:0] b);
        @(negedge core_clk);
        cam_data_i  = b;
        cam_href_i  = 1'b1;
        cam_vsync_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge core_clk);
            cam_data_i = '0;
            cam_href_i = 1'b0;
        end
    endtask

    task automatic pulse_vsync();
        repeat (VS_HIGH)
        begin
            @(negedge core_clk);
            cam_href_i  = 1'b0;
            cam_vsync_i = 1'b1;
        end
        repeat (VS_LOW)
        begin
            @(negedge core_clk);
            cam_vsync_i = 1'b0;
        end
    endtask

    task automatic drive_camera();
        int ln;
        int p;
        idle_cycles(SETTLE_CYCLES);
        pulse_vsync();                                 // store starts capturing
        for (ln = 0; ln < `V_ACTIVE; ln++)
        begin
            for (p = 0; p < `H_ACTIVE; p++)
            begin
                if (ln == STRAY_LINE && p == `H_ACTIVE / 2)
                begin
                    idle_cycles(2);
                    put_byte(stray_byte);              // lone byte, must be dropped
                    idle_cycles(2);
                end
                put_byte(stim_tab[ln * `H_ACTIVE + p].word[15:8]);  // high byte first
                put_byte(stim_tab[ln * `H_ACTIVE + p].word[7:0]);
            end
            idle_cycles(LINE_GAP);
        end
        vsync2_sent = 1'b1;
        pulse_vsync();                                 // frame done, display on
        idle_cycles(1);
    endtask

    //////////////////////////////
    // monitors
    //////////////////////////////
    task automatic check_heartbeat();
        logic prev;
        int   gap;
        int   t;
        for (t = 0; t < 3; t++)
        begin
            prev = heartbeat_o;
            gap  = 0;
            do
            begin
                @(negedge core_clk);
                gap++;
            end
            while (heartbeat_o == prev && gap < `HEARTBEAT_CYCLES);
            assert (heartbeat_o != prev)
            else abort_run("heartbeat_o did not toggle within the expected interval");
            compare_val("heartbeat_o interval", 24'(gap), 24'(`HEARTBEAT_CYCLES));
        end
    endtask

    task automatic check_display();
        int          f;
        int          c;
        int          idx;
        int          hs_pulses;
        int          hs_run;
        int          vs_cyc;
        int          vs_rises;
        logic        hs_prev;
        logic        vs_prev;
        logic [23:0] rgb;
        do
            @(negedge core_clk);
        while (!de_o);
        assert (vsync2_sent)
        else abort_run("de_o went high before the second vsync pulse was sent");
        for (f = 0; f < 2; f++)
        begin
            idx       = 0;
            hs_pulses = 0;
            hs_run    = 0;
            vs_cyc    = 0;
            vs_rises  = 0;
            hs_prev   = 1'b0;
            vs_prev   = 1'b0;
            for (c = 0; c < FRAME_CYCLES; c++)         // window starts at line 0 col 0
            begin
                rgb = {r_o, g_o, b_o};
                if (de_o)
                begin
                    assert (idx < `FRAME_WORDS)
                    else abort_run("more visible pixels in a frame than the store holds");
                    compare_val($sformatf("r_o frame %0d pixel %0d", f, idx), 24'(r_o),
                                24'(stim_tab[idx].r));
                    compare_val($sformatf("g_o frame %0d pixel %0d", f, idx), 24'(g_o),
                                24'(stim_tab[idx].g));
                    compare_val($sformatf("b_o frame %0d pixel %0d", f, idx), 24'(b_o),
                                24'(stim_tab[idx].b));
                    idx++;
                end
                else
                    compare_val("rgb outside de", rgb, 24'h0);
                if (hs_o)
                    hs_run++;
                if (hs_o && !hs_prev)
                    hs_pulses++;
                if (!hs_o && hs_prev)
                begin
                    compare_val("hs_o width", 24'(hs_run), 24'(`HS_WIDTH));
                    hs_run = 0;
                end
                if (vs_o)
                    vs_cyc++;
                if (vs_o && !vs_prev)
                    vs_rises++;
                hs_prev = hs_o;
                vs_prev = vs_o;
                @(negedge core_clk);
            end
            compare_val("de_o cycles per frame", 24'(idx), 24'(`FRAME_WORDS));
            compare_val("hs_o pulses per frame", 24'(hs_pulses), 24'(`V_TOTAL));
            compare_val("vs_o pulses per frame", 24'(vs_rises), 24'h1);
            compare_val("vs_o cycles per frame", 24'(vs_cyc), 24'(`H_TOTAL));
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        int i;
        rst_i       = 1'b1;
        cam_data_i  = '0;
        cam_href_i  = 1'b0;
        cam_vsync_i = 1'b0;
        vsync2_sent = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge core_clk);
        @(negedge core_clk);
        compare_val("vs_o after reset", 24'(vs_o), 24'h0);
        compare_val("hs_o after reset", 24'(hs_o), 24'h0);
        compare_val("de_o after reset", 24'(de_o), 24'h0);
        compare_val("heartbeat_o after reset", 24'(heartbeat_o), 24'h1);
        rst_i = 1'b0;
        for (i = 1; i <= `STARTUP_CYCLES; i++)         // ready exactly on the last one
        begin
            @(negedge core_clk);
            compare_val($sformatf("ready_o cycle %0d", i), 24'(ready_o),
                        24'(i == `STARTUP_CYCLES));
        end
        fork
            check_heartbeat();
            drive_camera();
            check_display();
        join
        $display("Simulation PASSED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the run did not finish in the expected time");
    end

endmodule

// ==== list.f ====
+incdir+include
src/video_pkg.sv
src/ctrl_pkg.sv
src/startup_timer.sv
src/frame_ctrl.sv
src/cam_pixel_pack.sv
src/frame_store.sv
src/video_timing.sv
src/video_out.sv
src/cam_display_top.sv
test/tb_cam_display.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the camera display testbench with Verilator.
# Exit status is zero only when the simulation passes.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f \
    --top-module tb_cam_display \
    -Mdir obj_dir \
    -o sim_cam_display
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_cam_display
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
